// ==== Bender.yml ====
package:
  name: eee_imgproc

sources:
  - include_dirs:
      - rtl
      - tb
    files:
      - rtl/imgproc_pkg.sv
      - rtl/hsv_convert.sv
      - rtl/colour_classifier.sv
      - rtl/frame_tracker.sv
      - rtl/msg_writer.sv
      - rtl/msg_fifo.sv
      - rtl/mm_regs.sv
      - rtl/eee_imgproc.sv
      - target: simulation
        files:
          - tb/tb_imgproc.sv

// ==== project.f ====
+incdir+rtl
+incdir+tb
rtl/imgproc_pkg.sv
rtl/hsv_convert.sv
rtl/colour_classifier.sv
rtl/frame_tracker.sv
rtl/msg_writer.sv
rtl/msg_fifo.sv
rtl/mm_regs.sv
rtl/eee_imgproc.sv
tb/tb_imgproc.sv

// ==== rtl/colour_classifier.sv ====
// ball colour classing on hsv with a run-length noise filter
`timescale 1ns/1ps
`include "imgproc_defs.svh"

module colour_classifier (
	input  logic clk,
	input  logic reset_n,
	input  logic accept,
	input  logic sop,
	input  imgproc_pkg::hsv_t hsv,
	output imgproc_pkg::colour_mask_t hits
);
	import imgproc_pkg::*;

	localparam int CW = $clog2(`RUN_LEN);
	localparam logic [CW-1:0] RUN_FULL = CW'(`RUN_LEN - 1);

	colour_mask_t raw;
	logic [3:0] match;
	logic [3:0] hit_vec;
	logic [CW-1:0] run [4];

	// inclusive range test
	function automatic logic in_range(logic [7:0] v, logic [7:0] lo, logic [7:0] hi);
		return (v >= lo) && (v <= hi);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// raw per-pixel tests
	//////////////////////////////////////////////////////////////////////
	assign raw.red = in_range(hsv.hue, `RED_H_MIN, `RED_H_MAX) &&
		(hsv.sat >= `RED_S_MIN) &&
		in_range(hsv.val, `RED_V_MIN, `RED_V_MAX);

	assign raw.yellow = in_range(hsv.hue, `YEL_H_MIN, `YEL_H_MAX) &&
		in_range(hsv.sat, `YEL_S_MIN, `YEL_S_MAX) &&
		(hsv.val >= `YEL_V_MIN);

	// strong teal, or a paler patch at lower hue
	assign raw.teal = (in_range(hsv.hue, `TEAL_H_MIN, `TEAL_H_MAX) &&
		(hsv.sat > `TEAL_S_LO) && (hsv.sat < `TEAL_S_HI) &&
		(hsv.val > `TEAL_V_LO) && (hsv.val < `TEAL_V_HI)) ||
		(in_range(hsv.hue, `TEAL_H_MIN, `TEAL2_H_MAX) &&
		(hsv.sat > `TEAL2_S_LO) && (hsv.sat < `TEAL2_S_HI) &&
		(hsv.val > `TEAL2_V_LO));

	assign raw.blue = in_range(hsv.hue, `BLUE_H_MIN, `BLUE_H_MAX) &&
		(hsv.sat >= `BLUE_S_MIN) &&
		in_range(hsv.val, `BLUE_V_MIN, `BLUE_V_MAX);

	assign match = raw;

	//////////////////////////////////////////////////////////////////////
	// run counters, saturate at RUN_LEN-1
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (!reset_n || (accept && (sop || !match[i])))
				run[i] <= '0;
			else if (accept && run[i] != RUN_FULL)
				run[i] <= run[i] + 1'b1;
		end
	end

	// a hit needs the earlier beats of this packet to match too
	always_comb begin
		for (int i = 0; i < 4; i++)
			hit_vec[i] = match[i] && (run[i] == RUN_FULL) && !sop;
	end

	assign hits = colour_mask_t'(hit_vec);

endmodule

// ==== rtl/eee_imgproc.sv ====
// ball-finding video filter top level
// stream output stage, pixel recolouring, bounds messages and register port
`timescale 1ns/1ps
`include "imgproc_defs.svh"

module eee_imgproc #(
	parameter int image_w = `IMAGE_W,
	parameter int horizon_y = `HORIZON_Y,
	parameter int msg_interval = `MSG_INTERVAL
) (
	input  logic clk,
	input  logic reset_n,
	input  logic s_chipselect,
	input  logic s_read,
	input  logic s_write,
	input  logic [2:0] s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata,
	input  imgproc_pkg::rgb_t sink_data,
	input  logic sink_valid,
	input  logic sink_sop,
	input  logic sink_eop,
	input  logic mode,
	output logic sink_ready,
	output imgproc_pkg::rgb_t source_data,
	output logic source_valid,
	output logic source_sop,
	output logic source_eop,
	input  logic source_ready
);
	import imgproc_pkg::*;

	pixel_beat_t in_beat, out_q;
	logic accept, video, frame_done;
	logic wr_en, pop, flush, fifo_empty;
	logic [5:0] fifo_used;
	hsv_t hsv;
	colour_mask_t hits;
	frame_bounds_t bounds;
	msg_word_t wr_data, fifo_q;
	logic [7:0] grey;
	rgb_t recolour, out_pix;

	assign in_beat = '{pix: sink_data, sop: sink_sop, eop: sink_eop};

	//////////////////////////////////////////////////////////////////////
	// output stream stage
	//////////////////////////////////////////////////////////////////////
	assign sink_ready = source_ready || !source_valid;
	assign accept = sink_valid && sink_ready;

	always_ff @(posedge clk) begin
		if (!reset_n)
			source_valid <= 1'b0;
		else if (accept)
			source_valid <= 1'b1;
		else if (source_ready)
			source_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept)
			out_q <= '{pix: out_pix, sop: in_beat.sop, eop: in_beat.eop};
	end

	assign source_data = out_q.pix;
	assign source_sop = out_q.sop;
	assign source_eop = out_q.eop;

	//////////////////////////////////////////////////////////////////////
	// recolouring
	//////////////////////////////////////////////////////////////////////
	// g/2 + r/4 + b/4
	assign grey = {1'b0, sink_data.g[7:1]} + {2'b00, sink_data.r[7:2]} +
		{2'b00, sink_data.b[7:2]};

	always_comb begin
		if (hits.red)
			recolour = rgb_t'(`HL_RED);
		else if (hits.teal)
			recolour = rgb_t'(`HL_TEAL);
		else if (hits.yellow)
			recolour = rgb_t'(`HL_YELLOW);
		else if (hits.blue)
			recolour = rgb_t'(`HL_BLUE);
		else
			recolour = '{r: grey, g: grey, b: grey};
	end

	// descriptor beat and non-video packets pass untouched
	assign out_pix = (mode && !in_beat.sop && video) ? recolour : in_beat.pix;

	hsv_convert u_hsv (
		.pixel (in_beat.pix),
		.hsv   (hsv)
	);

	colour_classifier u_class (
		.clk     (clk),
		.reset_n (reset_n),
		.accept  (accept),
		.sop     (in_beat.sop),
		.hsv     (hsv),
		.hits    (hits)
	);

	frame_tracker #(
		.image_w   (image_w),
		.horizon_y (horizon_y)
	) u_track (
		.clk        (clk),
		.reset_n    (reset_n),
		.accept     (accept),
		.beat       (in_beat),
		.hits       (hits),
		.video      (video),
		.bounds     (bounds),
		.frame_done (frame_done)
	);

	msg_writer #(
		.msg_interval (msg_interval)
	) u_writer (
		.clk        (clk),
		.reset_n    (reset_n),
		.frame_done (frame_done),
		.bounds     (bounds),
		.fifo_used  (fifo_used),
		.wr_data    (wr_data),
		.wr_en      (wr_en)
	);

	msg_fifo u_fifo (
		.clk     (clk),
		.reset_n (reset_n),
		.wr_en   (wr_en),
		.rd_en   (pop),
		.flush   (flush),
		.wr_data (wr_data),
		.q       (fifo_q),
		.used    (fifo_used),
		.empty   (fifo_empty)
	);

	mm_regs u_regs (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.s_readdata   (s_readdata),
		.fifo_q       (fifo_q),
		.fifo_used    (fifo_used),
		.fifo_empty   (fifo_empty),
		.pop          (pop),
		.flush        (flush)
	);

endmodule

// ==== rtl/frame_tracker.sv ====
// pixel coordinates, packet type and per-frame horizontal colour bounds
// bounds latch at the end of every video packet
`timescale 1ns/1ps

module frame_tracker #(
	parameter int image_w = 640,
	parameter int horizon_y = 280
) (
	input  logic clk,
	input  logic reset_n,
	input  logic accept,
	input  imgproc_pkg::pixel_beat_t beat,
	input  imgproc_pkg::colour_mask_t hits,
	output logic video,
	output imgproc_pkg::frame_bounds_t bounds,
	output logic frame_done
);
	import imgproc_pkg::*;

	localparam span_t EMPTY = '{x_min: coord_t'(image_w - 1), x_max: '0};

	coord_t x, y;
	frame_bounds_t run_b;
	logic in_zone;
	logic frame_end;

	// widen one span by the current x
	function automatic span_t widen(span_t s, logic hit, coord_t pos);
		span_t r;
		r = s;
		if (hit && pos < s.x_min)
			r.x_min = pos;
		if (hit && pos > s.x_max)
			r.x_max = pos;
		return r;
	endfunction

	// only pixel beats strictly below the horizon row
	assign in_zone = accept && !beat.sop && !beat.eop && (y > coord_t'(horizon_y));
	assign frame_end = accept && beat.eop && !beat.sop && video;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			video <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= frame_end;
			if (accept && beat.sop) begin
				x <= '0;
				y <= '0;
				// packet descriptor, video packets carry type 0
				video <= (beat.pix.b[3:0] == 4'h0);
			end else if (accept) begin
				if (x == coord_t'(image_w - 1)) begin
					x <= '0;
					y <= y + 1'b1;
				end else begin
					x <= x + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && beat.sop) begin
			run_b <= '{EMPTY, EMPTY, EMPTY, EMPTY};
		end else if (in_zone) begin
			run_b.red <= widen(run_b.red, hits.red, x);
			run_b.yellow <= widen(run_b.yellow, hits.yellow, x);
			run_b.teal <= widen(run_b.teal, hits.teal, x);
			run_b.blue <= widen(run_b.blue, hits.blue, x);
		end
		if (frame_end)
			bounds <= run_b;
	end

endmodule

// ==== rtl/hsv_convert.sv ====
// rgb to hsv conversion of one pixel, purely combinational
// hue on a half-degree scale (0..180)
`timescale 1ns/1ps

module hsv_convert (
	input  imgproc_pkg::rgb_t pixel,
	output imgproc_pkg::hsv_t hsv
);
	import imgproc_pkg::*;

	logic [7:0] val;
	logic [7:0] min_c;
	logic [7:0] dif;
	logic [7:0] div_v;
	logic [15:0] sat_prod;
	logic [15:0] sat_q;
	logic [7:0] sat_c;
	logic signed [9:0] rs, gs, bs, ds, div_s;
	logic signed [18:0] num;
	logic signed [18:0] quo;
	logic [7:0] hue_c;

	assign val = (pixel.r > pixel.g) ? ((pixel.r > pixel.b) ? pixel.r : pixel.b) :
		((pixel.g > pixel.b) ? pixel.g : pixel.b);
	assign min_c = (pixel.r < pixel.g) ? ((pixel.r < pixel.b) ? pixel.r : pixel.b) :
		((pixel.g < pixel.b) ? pixel.g : pixel.b);
	assign dif = val - min_c;

	// saturation, zero for a black pixel
	assign div_v = (val == 8'd0) ? 8'd1 : val;
	assign sat_prod = {8'h00, dif} * 16'd255;
	assign sat_q = sat_prod / {8'h00, div_v};
	assign sat_c = (val == 8'd0) ? 8'd0 : sat_q[7:0];

	assign rs = signed'({2'b00, pixel.r});
	assign gs = signed'({2'b00, pixel.g});
	assign bs = signed'({2'b00, pixel.b});
	assign ds = signed'({2'b00, dif});
	assign div_s = (dif == 8'd0) ? 10'sd1 : ds;

	// hue sector by maximal channel, red wins ties
	always_comb begin
		if (val == pixel.r) begin
			if (pixel.b < pixel.g)
				num = 19'(60 * (gs - bs));
			else
				num = 19'(360 * ds + 60 * (gs - bs));
		end else if (val == pixel.g) begin
			num = 19'(120 * ds + 60 * (bs - rs));
		end else begin
			num = 19'(240 * ds + 60 * (rs - gs));
		end
	end

	assign quo = num / div_s;
	assign hue_c = (pixel.r == pixel.g && pixel.r == pixel.b) ? 8'd0 : quo[8:1];

	assign hsv = '{hue: hue_c, sat: sat_c, val: val};

endmodule

// ==== rtl/imgproc_defs.svh ====
// image processing constants
// image size, colour thresholds, message format and register map
`ifndef IMGPROC_DEFS_SVH
`define IMGPROC_DEFS_SVH

// image and framing defaults
`define IMAGE_W       640
`define HORIZON_Y     280
`define MSG_INTERVAL  6
`define RUN_LEN       4

// message fifo
`define FIFO_DEPTH    32
`define MSG_WORDS     5
`define MSG_ID_WORD   32'h0052_4242
`define IMGPROC_ID    32'h1234_EEE2

// register map
`define REG_STATUS    3'd0
`define REG_MSG       3'd1
`define REG_ID        3'd2
`define FLUSH_BIT     4

// red ball limits
`define RED_H_MIN     8'd7
`define RED_H_MAX     8'd12
`define RED_S_MIN     8'd220
`define RED_V_MIN     8'd75
`define RED_V_MAX     8'd189

// yellow ball limits
`define YEL_H_MIN     8'd24
`define YEL_H_MAX     8'd31
`define YEL_S_MIN     8'd179
`define YEL_S_MAX     8'd214
`define YEL_V_MIN     8'd244

// teal, two ranges, sat/val bounds exclusive
`define TEAL_H_MIN    8'd69
`define TEAL_H_MAX    8'd85
`define TEAL_S_LO     8'd100
`define TEAL_S_HI     8'd200
`define TEAL_V_LO     8'd110
`define TEAL_V_HI     8'd245
`define TEAL2_H_MAX   8'd80
`define TEAL2_S_LO    8'd80
`define TEAL2_S_HI    8'd114
`define TEAL2_V_LO    8'd60

// blue ball limits
`define BLUE_H_MIN    8'd92
`define BLUE_H_MAX    8'd118
`define BLUE_S_MIN    8'd174
`define BLUE_V_MIN    8'd23
`define BLUE_V_MAX    8'd36

// highlight colours
`define HL_RED        24'hff1000
`define HL_TEAL       24'h008080
`define HL_YELLOW     24'hffff00
`define HL_BLUE       24'h00008b

`endif

// ==== rtl/imgproc_pkg.sv ====
// shared types of the ball-finding filter
// pixels, hsv, colour masks, bounds and fifo words
package imgproc_pkg;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// one stream beat with packet markers
	typedef struct packed {
		rgb_t pix;
		logic sop;
		logic eop;
	} pixel_beat_t;

	typedef struct packed {
		logic [7:0] hue;
		logic [7:0] sat;
		logic [7:0] val;
	} hsv_t;

	// one bit per ball colour
	typedef struct packed {
		logic red;
		logic yellow;
		logic teal;
		logic blue;
	} colour_mask_t;

	typedef logic [10:0] coord_t;

	typedef struct packed {
		coord_t x_min;
		coord_t x_max;
	} span_t;

	typedef struct packed {
		span_t red;
		span_t yellow;
		span_t teal;
		span_t blue;
	} frame_bounds_t;

	typedef logic [31:0] msg_word_t;

endpackage

// ==== rtl/mm_regs.sv ====
// memory-mapped register port
// status with fifo fill and flush, message read with pop, id
`timescale 1ns/1ps
`include "imgproc_defs.svh"

module mm_regs (
	input  logic clk,
	input  logic reset_n,
	input  logic s_chipselect,
	input  logic s_read,
	input  logic s_write,
	input  logic [2:0] s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata,
	input  imgproc_pkg::msg_word_t fifo_q,
	input  logic [5:0] fifo_used,
	input  logic fifo_empty,
	output logic pop,
	output logic flush
);

	logic [7:0] status;
	logic rd_req;
	logic rd_d;
	logic wr_status;

	assign rd_req = s_chipselect && s_read;
	assign wr_status = s_chipselect && s_write && (s_address == `REG_STATUS);

	// pop only on the first cycle of a message read
	assign pop = rd_req && !rd_d && !fifo_empty && (s_address == `REG_MSG);
	assign flush = wr_status && s_writedata[`FLUSH_BIT];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status <= '0;
			rd_d <= 1'b0;
			s_readdata <= '0;
		end else begin
			rd_d <= rd_req;
			if (wr_status)
				status <= s_writedata[7:0];
			if (rd_req) begin
				case (s_address)
					`REG_STATUS: s_readdata <= {16'h0, 2'b00, fifo_used, status};
					`REG_MSG:    s_readdata <= fifo_q;
					`REG_ID:     s_readdata <= `IMGPROC_ID;
					default:     s_readdata <= '0;
				endcase
			end
		end
	end

endmodule

// ==== rtl/msg_fifo.sv ====
// synchronous message fifo with fill count, flush and show-ahead head word
`timescale 1ns/1ps
`include "imgproc_defs.svh"

module msg_fifo (
	input  logic clk,
	input  logic reset_n,
	input  logic wr_en,
	input  logic rd_en,
	input  logic flush,
	input  imgproc_pkg::msg_word_t wr_data,
	output imgproc_pkg::msg_word_t q,
	output logic [5:0] used,
	output logic empty
);
	import imgproc_pkg::*;

	localparam int AW = $clog2(`FIFO_DEPTH);

	msg_word_t mem [`FIFO_DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic do_wr, do_rd;

	// writes into a full buffer are dropped
	assign do_wr = wr_en && (used != 6'(`FIFO_DEPTH));
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			used <= used + 6'(do_wr) - 6'(do_rd);
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	assign empty = (used == 6'd0);
	assign q = empty ? '0 : mem[rd_ptr];

endmodule

// ==== rtl/msg_writer.sv ====
// frame-interval counter and five-word bounds message sequencer
`timescale 1ns/1ps
`include "imgproc_defs.svh"

module msg_writer #(
	parameter int msg_interval = 6
) (
	input  logic clk,
	input  logic reset_n,
	input  logic frame_done,
	input  imgproc_pkg::frame_bounds_t bounds,
	input  logic [5:0] fifo_used,
	output imgproc_pkg::msg_word_t wr_data,
	output logic wr_en
);
	import imgproc_pkg::*;

	localparam logic [5:0] ROOM = 6'(`FIFO_DEPTH - `MSG_WORDS);
	localparam logic [2:0] LAST = 3'(`MSG_WORDS - 1);

	logic [7:0] frame_cnt;
	logic active;
	logic [2:0] idx;

	// tag, pad, x_min, x_max
	function automatic msg_word_t colour_word(logic [3:0] tag, span_t s);
		return {tag, 6'b0, s.x_min, s.x_max};
	endfunction

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
			active <= 1'b0;
			idx <= '0;
		end else begin
			if (active) begin
				active <= (idx != LAST);
				idx <= (idx == LAST) ? 3'd0 : idx + 1'b1;
			end
			if (frame_done) begin
				if (frame_cnt != 8'd0)
					frame_cnt <= frame_cnt - 1'b1;
				else if (fifo_used <= ROOM && !active) begin
					frame_cnt <= 8'(msg_interval - 1);
					active <= 1'b1;
					idx <= 3'd0;
				end
			end
		end
	end

	assign wr_en = active;

	always_comb begin
		case (idx)
			3'd0: wr_data = `MSG_ID_WORD;
			3'd1: wr_data = colour_word(4'd1, bounds.red);
			3'd2: wr_data = colour_word(4'd2, bounds.yellow);
			3'd3: wr_data = colour_word(4'd3, bounds.teal);
			3'd4: wr_data = colour_word(4'd4, bounds.blue);
			default: wr_data = '0;
		endcase
	end

endmodule

// ==== tb/tb_checks.svh ====
// typed compare tasks and stream and register drivers
// drivers start and end 2 ns after a rising edge
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_pixel(input string name, input rgb_t got, input rgb_t exp);
	if (got !== exp)
		fail_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
endtask

task automatic check_word(input string name, input msg_word_t got, input msg_word_t exp);
	if (got !== exp)
		fail_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
endtask

task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		fail_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
endtask

// hold the beat until the sink takes it
task automatic send_beat(input pixel_beat_t beat);
	logic taken;
	sink_data = beat.pix;
	sink_sop = beat.sop;
	sink_eop = beat.eop;
	sink_valid = 1'b1;
	taken = 1'b0;
	while (!taken) begin
		@(negedge clk);
		taken = sink_ready;
		@(posedge clk);
		#2;
	end
	sink_valid = 1'b0;
endtask

// one-cycle read, then an idle cycle so the next read pops again
task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
	s_chipselect = 1'b1;
	s_read = 1'b1;
	s_address = addr;
	@(posedge clk);
	#2;
	s_chipselect = 1'b0;
	s_read = 1'b0;
	data = s_readdata;
	@(posedge clk);
	#2;
endtask

task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
	s_chipselect = 1'b1;
	s_write = 1'b1;
	s_address = addr;
	s_writedata = data;
	@(posedge clk);
	#2;
	s_chipselect = 1'b0;
	s_write = 1'b0;
	@(posedge clk);
	#2;
endtask

`endif

// ==== tb/tb_imgproc.sv ====
// testbench of the ball-finding video filter
// frames from a pixel table, scoreboard on the output stream, message and register checks
`timescale 1ns/1ps
`include "imgproc_defs.svh"

module tb_imgproc;
	import imgproc_pkg::*;

	localparam int IMG_W = 16;
	localparam int HORIZON = 1;
	localparam int INTERVAL = 2;
	localparam int ROWS = 4;
	localparam int NO_CLASS = 4;
	localparam int FRAME_BEATS = ROWS * IMG_W + 2;
	localparam int TOTAL_BEATS = 3 * FRAME_BEATS;
	localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 2000;
	localparam logic [31:0] SEED = 32'he296_02da;

	// table entry: input pixel, expected class, expected output once the run holds
	typedef struct packed {
		rgb_t pix;
		colour_mask_t cls;
		rgb_t exp_out;
	} stim_t;

	logic clk;
	logic reset_n;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	logic [2:0] s_address;
	logic [31:0] s_writedata;
	logic [31:0] s_readdata;
	rgb_t sink_data;
	logic sink_valid;
	logic sink_sop;
	logic sink_eop;
	logic mode;
	logic sink_ready;
	rgb_t source_data;
	logic source_valid;
	logic source_sop;
	logic source_eop;
	logic source_ready;

	stim_t tbl [5] = '{
		{24'hb43200, 4'b1000, `HL_RED},
		{24'hfaf032, 4'b0100, `HL_YELLOW},
		{24'h3cc896, 4'b0010, `HL_TEAL},
		{24'h000a1e, 4'b0001, `HL_BLUE},
		{24'h646464, 4'b0000, 24'h646464}
	};

	// one run per row, rows 0 and 1 lie above the horizon
	int run_idx [ROWS] = '{1, 3, 0, 2};
	int run_lo [ROWS] = '{2, 4, 3, 5};
	int run_hi [ROWS] = '{8, 10, 9, 12};

	pixel_beat_t sb [$];
	pixel_beat_t out_exp;
	int exp_min [4];
	int exp_max [4];
	int cycle_count;
	logic [31:0] rd;

	eee_imgproc #(
		.image_w      (IMG_W),
		.horizon_y    (HORIZON),
		.msg_interval (INTERVAL)
	) DUT (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.s_readdata   (s_readdata),
		.sink_data    (sink_data),
		.sink_valid   (sink_valid),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.mode         (mode),
		.sink_ready   (sink_ready),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.source_ready (source_ready)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	`include "tb_checks.svh"

	//////////////////////////////////////////////////////////////////////
	// clock, back-pressure, watchdog and output monitor
	//////////////////////////////////////////////////////////////////////
	always #20 clk = ~clk;

	// ready low on about one cycle in four
	initial begin
		void'($urandom(SEED));
		source_ready = 1'b1;
		forever begin
			@(posedge clk);
			#2;
			source_ready = ($urandom % 4) != 0;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			fail_run("timeout, the test sequence did not finish in time");
	end

	always @(negedge clk) begin
		if (reset_n) begin
			// a full stage that is stalled holds off the sink
			if (source_valid && !source_ready)
				check_reg("sink_ready", {31'b0, sink_ready}, 32'h0);
			else
				check_reg("sink_ready", {31'b0, sink_ready}, 32'h1);
		end
		if (reset_n && source_valid && source_ready) begin
			if (sb.size() == 0) begin
				fail_run("an output beat came out while none was expected");
			end else begin
				out_exp = sb.pop_front();
				check_pixel("source_data", source_data, out_exp.pix);
				check_reg("source_sop_eop", {30'b0, source_sop, source_eop},
					{30'b0, out_exp.sop, out_exp.eop});
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// expected values from the filter rules
	//////////////////////////////////////////////////////////////////////
	function automatic rgb_t grey_of(input rgb_t p);
		logic [7:0] v;
		v = (p.g >> 1) + (p.r >> 2) + (p.b >> 2);
		return {v, v, v};
	endfunction

	function automatic int entry_at(input int y, input int x);
		if (x >= run_lo[y] && x <= run_hi[y])
			return run_idx[y];
		return NO_CLASS;
	endfunction

	// tag, x_min, x_max of one colour
	function automatic msg_word_t colour_msg(input int c);
		return {4'(c + 1), 6'b0, 11'(exp_min[c]), 11'(exp_max[c])};
	endfunction

	task automatic run_frame(input logic md);
		rgb_t want;
		int idx;
		int prev;
		int streak;
		logic hit;
		mode = md;
		for (int c = 0; c < 4; c++) begin
			exp_min[c] = IMG_W - 1;
			exp_max[c] = 0;
		end
		// descriptor beat, type 0 is video
		sb.push_back({24'h000000, 1'b1, 1'b0});
		send_beat({24'h000000, 1'b1, 1'b0});
		prev = NO_CLASS;
		streak = 0;
		for (int y = 0; y < ROWS; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				idx = entry_at(y, x);
				if (idx == prev && tbl[idx].cls != '0)
					streak++;
				else
					streak = 0;
				prev = idx;
				hit = (tbl[idx].cls != '0) && (streak >= `RUN_LEN - 1);
				if (hit && y > HORIZON) begin
					for (int c = 0; c < 4; c++) begin
						if (tbl[idx].cls[3 - c] && x < exp_min[c])
							exp_min[c] = x;
						if (tbl[idx].cls[3 - c] && x > exp_max[c])
							exp_max[c] = x;
					end
				end
				want = tbl[idx].pix;
				if (md)
					want = hit ? tbl[idx].exp_out : grey_of(tbl[idx].pix);
				sb.push_back({want, 1'b0, 1'b0});
				send_beat({tbl[idx].pix, 1'b0, 1'b0});
			end
		end
		want = md ? grey_of(tbl[NO_CLASS].pix) : tbl[NO_CLASS].pix;
		sb.push_back({want, 1'b0, 1'b1});
		send_beat({tbl[NO_CLASS].pix, 1'b0, 1'b1});
	endtask

	// message writes end a fixed few cycles after the last beat
	task automatic drain_and_settle();
		while (sb.size() != 0)
			@(posedge clk);
		repeat (`MSG_WORDS + 3) @(posedge clk);
		#2;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		mode = 1'b0;
		cycle_count = 0;
		repeat (16) @(posedge clk);
		#2;
		reset_n = 1'b1;

		check_reg("source_valid", {31'b0, source_valid}, 32'h0);
		read_reg(`REG_STATUS, rd);
		check_reg("reg_status", rd, 32'h0);
		read_reg(`REG_ID, rd);
		check_reg("reg_id", rd, `IMGPROC_ID);

		// pass-through frame, first message
		run_frame(1'b0);
		drain_and_settle();
		read_reg(`REG_STATUS, rd);
		check_reg("reg_status", rd, 32'(`MSG_WORDS) << 8);
		read_reg(`REG_MSG, rd);
		check_word("reg_msg", rd, `MSG_ID_WORD);
		for (int c = 0; c < 4; c++) begin
			read_reg(`REG_MSG, rd);
			check_word("reg_msg", rd, colour_msg(c));
		end
		read_reg(`REG_STATUS, rd);
		check_reg("reg_status", rd, 32'h0);

		// highlight frames, only the second of them sends
		run_frame(1'b1);
		drain_and_settle();
		read_reg(`REG_STATUS, rd);
		check_reg("reg_status", rd, 32'h0);
		run_frame(1'b1);
		drain_and_settle();
		read_reg(`REG_STATUS, rd);
		check_reg("reg_status", rd, 32'(`MSG_WORDS) << 8);

		write_reg(`REG_STATUS, 32'h1 << `FLUSH_BIT);
		read_reg(`REG_STATUS, rd);
		check_reg("reg_status", rd, 32'h1 << `FLUSH_BIT);
		read_reg(`REG_MSG, rd);
		check_word("reg_msg", rd, 32'h0);

		if (sb.size() != 0) begin
			fail_run("expected output beats never came out");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule
